// ==== cic_cfg.svh ====
`ifndef CIC_CFG_SVH
`define CIC_CFG_SVH

// Rail width at every stage
`define CIC_WIDTH 16

// Output samples per input sample
`define CIC_FACTOR 4

// Comb count, equal to integrator count
`define CIC_STAGES 3
`define CIC_DELAY 1

`define CIC_FIFO_DEPTH 4

`endif

// ==== cic_pkg.sv ====
`default_nettype none

`include "cic_cfg.svh"

package cic_pkg;

    // Width of the interpolation phase count, at least one bit
    localparam int PHASE_WIDTH = (`CIC_FACTOR > 1) ? $clog2(`CIC_FACTOR) : 1;

    // One complex sample, in-phase in the upper half
    typedef struct packed {
        logic [`CIC_WIDTH-1:0] inph;
        logic [`CIC_WIDTH-1:0] quad;
    } iq_sample_t;

    // Counts 0 to CIC_FACTOR-1
    typedef logic [PHASE_WIDTH-1:0] phase_t;

endpackage : cic_pkg

`default_nettype wire

// ==== iq_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream of I/Q samples
interface iq_stream_if;
    import cic_pkg::*;

    logic       valid;
    logic       ready;
    iq_sample_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface : iq_stream_if

`default_nettype wire

// ==== cic_comb_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_comb_chain (
    input  logic        i_clock,
    input  logic        i_reset,
    iq_stream_if.sink   s_in,
    iq_stream_if.source m_out
);
    import cic_pkg::*;

    localparam int STAGES = `CIC_STAGES;
    localparam int DELAY  = `CIC_DELAY;

    // Per-stage input history, oldest entry at DELAY-1
    iq_sample_t hist [STAGES][DELAY];
    iq_sample_t comb_data [STAGES+1];
    iq_sample_t out_data;
    logic       out_valid;
    logic       in_fire;

    assign s_in.ready = !out_valid || m_out.ready;
    assign in_fire    = s_in.valid && s_in.ready;

    // Comb stages cascade without registers between them
    always_comb begin
        comb_data[0] = s_in.data;
        for (int k = 0; k < STAGES; k++) begin
            comb_data[k+1].inph = comb_data[k].inph - hist[k][DELAY-1].inph;
            comb_data[k+1].quad = comb_data[k].quad - hist[k][DELAY-1].quad;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int k = 0; k < STAGES; k++) begin
                for (int d = 0; d < DELAY; d++) begin
                    hist[k][d] <= '0;
                end
            end
        end else if (in_fire) begin
            for (int k = 0; k < STAGES; k++) begin
                hist[k][0] <= comb_data[k];
                for (int d = 1; d < DELAY; d++) begin
                    hist[k][d] <= hist[k][d-1];
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (m_out.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (in_fire) begin
            out_data <= comb_data[STAGES];
        end
    end

    assign m_out.valid = out_valid;
    assign m_out.data  = out_data;

endmodule : cic_comb_chain

`default_nettype wire

// ==== cic_sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_sample_fifo #(
    parameter int DEPTH = `CIC_FIFO_DEPTH
) (
    input  logic        i_clock,
    input  logic        i_reset,
    iq_stream_if.sink   s_in,
    iq_stream_if.source m_out
);
    import cic_pkg::*;

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    iq_sample_t           mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 full;
    logic                 empty;
    logic                 push;
    logic                 pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        logic [PTR_WIDTH-1:0] nxt;
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    // A full FIFO still takes a push when the head leaves this cycle
    assign s_in.ready  = !full || m_out.ready;
    assign m_out.valid = !empty;
    assign m_out.data  = mem[rd_ptr];

    assign push = s_in.valid && s_in.ready;
    assign pop  = m_out.valid && m_out.ready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (push) begin
            mem[wr_ptr] <= s_in.data;
        end
    end

endmodule : cic_sample_fifo

`default_nettype wire

// ==== cic_integrator_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_integrator_chain (
    input  logic               i_clock,
    input  logic               i_reset,
    iq_stream_if.sink          s_in,
    output logic               o_out_valid,
    input  logic               i_out_ready,
    output cic_pkg::iq_sample_t o_out_sample
);
    import cic_pkg::*;

    localparam int STAGES = `CIC_STAGES;
    localparam int FACTOR = `CIC_FACTOR;

    iq_sample_t acc [STAGES];
    iq_sample_t sum [STAGES];
    iq_sample_t stuffed;
    iq_sample_t out_data;
    phase_t     phase;
    logic       out_valid;
    logic       out_free;
    logic       step;

    // Output register is empty or being taken
    assign out_free = !out_valid || i_out_ready;

    // New samples enter only at phase 0
    assign s_in.ready = out_free && (phase == '0);
    assign step       = out_free && ((phase != '0) || s_in.valid);

    // Zero stuffing between input samples
    assign stuffed = (phase == '0) ? s_in.data : '0;

    // Integrators chained through their next values
    always_comb begin
        sum[0].inph = acc[0].inph + stuffed.inph;
        sum[0].quad = acc[0].quad + stuffed.quad;
        for (int k = 1; k < STAGES; k++) begin
            sum[k].inph = acc[k].inph + sum[k-1].inph;
            sum[k].quad = acc[k].quad + sum[k-1].quad;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int k = 0; k < STAGES; k++) begin
                acc[k] <= '0;
            end
        end else if (step) begin
            for (int k = 0; k < STAGES; k++) begin
                acc[k] <= sum[k];
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase <= '0;
        end else if (step) begin
            if (phase == phase_t'(FACTOR - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Output register holds while the sink stalls
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            out_valid <= 1'b0;
        end else if (step) begin
            out_valid <= 1'b1;
        end else if (i_out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (step) begin
            out_data <= sum[STAGES-1];
        end
    end

    assign o_out_valid  = out_valid;
    assign o_out_sample = out_data;

endmodule : cic_integrator_chain

`default_nettype wire

// ==== cic_interp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_interp_top (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_in_valid,
    output logic                  o_in_ready,
    input  logic [`CIC_WIDTH-1:0] i_in_inph,
    input  logic [`CIC_WIDTH-1:0] i_in_quad,
    output logic                  o_out_valid,
    input  logic                  i_out_ready,
    output logic [`CIC_WIDTH-1:0] o_out_inph,
    output logic [`CIC_WIDTH-1:0] o_out_quad
);
    import cic_pkg::*;

    iq_sample_t out_sample;

    iq_stream_if in_stream ();
    iq_stream_if comb_to_fifo ();
    iq_stream_if fifo_to_integ ();

    // Input rails into the comb stream
    assign in_stream.valid     = i_in_valid;
    assign in_stream.data.inph = i_in_inph;
    assign in_stream.data.quad = i_in_quad;
    assign o_in_ready          = in_stream.ready;

    cic_comb_chain i_comb (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .s_in    (in_stream.sink),
        .m_out   (comb_to_fifo.source)
    );

    cic_sample_fifo #(
        .DEPTH (`CIC_FIFO_DEPTH)
    ) i_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .s_in    (comb_to_fifo.sink),
        .m_out   (fifo_to_integ.source)
    );

    cic_integrator_chain i_integ (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .s_in         (fifo_to_integ.sink),
        .o_out_valid  (o_out_valid),
        .i_out_ready  (i_out_ready),
        .o_out_sample (out_sample)
    );

    assign o_out_inph = out_sample.inph;
    assign o_out_quad = out_sample.quad;

endmodule : cic_interp_top

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clock,
    output logic o_reset
);

    initial begin
        o_clock = 1'b0;
        forever #HALF_PERIOD o_clock = ~o_clock;
    end

    // Power-on reset, released just after a rising edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #2;
        o_reset = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== cic_interp_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_interp_sva (
    input logic                  i_clock,
    input logic                  i_reset,
    input logic                  i_in_valid,
    input logic                  i_in_ready,
    input logic [`CIC_WIDTH-1:0] i_in_inph,
    input logic [`CIC_WIDTH-1:0] i_in_quad,
    input logic                  i_out_valid,
    input logic                  i_out_ready,
    input logic [`CIC_WIDTH-1:0] i_out_inph,
    input logic [`CIC_WIDTH-1:0] i_out_quad
);

    int unsigned fail_count = 0;

    out_valid_low_in_reset : assert property (@(posedge i_clock)
        i_reset |=> !i_out_valid)
    else begin
        fail_count++;
        $error("o_out_valid high after a reset cycle");
    end

    // Output held while the sink stalls
    out_stable_when_stalled : assert property (@(posedge i_clock) disable iff (i_reset)
        i_out_valid && !i_out_ready |=>
            i_out_valid && $stable(i_out_inph) && $stable(i_out_quad))
    else begin
        fail_count++;
        $error("output changed while i_out_ready was low");
    end

    in_stable_when_stalled : assert property (@(posedge i_clock) disable iff (i_reset)
        i_in_valid && !i_in_ready |=>
            i_in_valid && $stable(i_in_inph) && $stable(i_in_quad))
    else begin
        fail_count++;
        $error("input stream changed before it was accepted");
    end

endmodule : cic_interp_sva

bind cic_interp_top cic_interp_sva i_sva (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_valid  (i_in_valid),
    .i_in_ready  (o_in_ready),
    .i_in_inph   (i_in_inph),
    .i_in_quad   (i_in_quad),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_inph  (o_out_inph),
    .i_out_quad  (o_out_quad)
);

`default_nettype wire

// ==== cic_interp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_interp_tb;
    import cic_pkg::*;

    localparam int W              = `CIC_WIDTH;
    localparam int FACTOR         = `CIC_FACTOR;
    localparam int STAGES         = `CIC_STAGES;
    localparam int DELAY          = `CIC_DELAY;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 4000;

    logic         clock;
    logic         gen_reset;
    logic         tb_reset;
    logic         reset;
    logic         in_valid;
    logic         in_ready;
    logic [W-1:0] in_inph;
    logic [W-1:0] in_quad;
    logic         out_valid;
    logic         out_ready;
    logic [W-1:0] out_inph;
    logic [W-1:0] out_quad;

    // Golden model state per rail, 0 is in-phase
    logic [W-1:0] comb_hist [2][STAGES][DELAY];
    logic [W-1:0] integ_acc [2][STAGES];
    iq_sample_t   expected_q [$];

    string        test_name;
    int           error_count;
    int           in_count;
    int           out_count;
    int           ready_mode;
    logic [31:0]  stim_state;
    logic [31:0]  ready_state;

    assign reset = gen_reset | tb_reset;

    tb_clock_gen i_clock_gen (
        .o_clock (clock),
        .o_reset (gen_reset)
    );

    cic_interp_top i_dut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_in_valid  (in_valid),
        .o_in_ready  (in_ready),
        .i_in_inph   (in_inph),
        .i_in_quad   (in_quad),
        .o_out_valid (out_valid),
        .i_out_ready (out_ready),
        .o_out_inph  (out_inph),
        .o_out_quad  (out_quad)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic model_reset();
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < STAGES; k++) begin
                integ_acc[r][k] = '0;
                for (int d = 0; d < DELAY; d++) begin
                    comb_hist[r][k][d] = '0;
                end
            end
        end
        expected_q.delete();
        in_count  = 0;
        out_count = 0;
    endtask

    // One input sample in, FACTOR expected outputs queued
    task automatic model_input(input logic [W-1:0] x_inph, input logic [W-1:0] x_quad);
        logic [W-1:0] value;
        logic [W-1:0] diff;
        logic [W-1:0] comb_out [2];
        iq_sample_t   result;
        phase_t       p;
        comb_out[0] = x_inph;
        comb_out[1] = x_quad;
        for (int r = 0; r < 2; r++) begin
            value = comb_out[r];
            for (int k = 0; k < STAGES; k++) begin
                diff = value - comb_hist[r][k][DELAY-1];
                for (int j = DELAY - 1; j > 0; j--) begin
                    comb_hist[r][k][j] = comb_hist[r][k][j-1];
                end
                comb_hist[r][k][0] = value;
                value = diff;
            end
            comb_out[r] = value;
        end
        for (int n = 0; n < FACTOR; n++) begin
            p = phase_t'(n);
            for (int r = 0; r < 2; r++) begin
                value = (p == '0) ? comb_out[r] : '0;
                for (int k = 0; k < STAGES; k++) begin
                    integ_acc[r][k] = integ_acc[r][k] + value;
                    value = integ_acc[r][k];
                end
                if (r == 0) begin
                    result.inph = value;
                end else begin
                    result.quad = value;
                end
            end
            expected_q.push_back(result);
        end
    endtask

    // Transfers are seen at the falling edge before the rising edge that takes them
    always @(negedge clock) begin
        if (!reset && in_valid && in_ready) begin
            model_input(in_inph, in_quad);
            in_count++;
        end
        if (!reset && out_valid && out_ready) begin
            out_count++;
            if (expected_q.size() == 0) begin
                $display("Unexpected output sample in %s with nothing left in the model",
                         test_name);
                error_count++;
            end else begin
                check_value(test_name, expected_q.pop_front(), {out_inph, out_quad});
            end
        end
    end

    // Output ready pattern: 0 always, 1 random, 2 held low
    always @(posedge clock) begin
        #2;
        ready_state = lcg_next(ready_state);
        case (ready_mode)
            0:       out_ready = 1'b1;
            1:       out_ready = ready_state[31] | ready_state[30];
            default: out_ready = 1'b0;
        endcase
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic set_ready_mode(input int mode);
        @(negedge clock);
        ready_mode = mode;
        next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        in_count  = 0;
        out_count = 0;
    endtask

    task automatic draw_sample();
        stim_state = lcg_next(stim_state);
        in_inph    = stim_state[31 -: W];
        stim_state = lcg_next(stim_state);
        in_quad    = stim_state[31 -: W];
    endtask

    task automatic hold_until_accepted();
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < ACCEPT_TIMEOUT) begin
            @(negedge clock);
            taken = in_ready;
            next_cycle();
            waited++;
        end
        if (!taken) begin
            $display("Timeout in %s: an input sample was never accepted", test_name);
            error_count++;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_sample(input logic [W-1:0] x_inph, input logic [W-1:0] x_quad);
        in_inph  = x_inph;
        in_quad  = x_quad;
        in_valid = 1'b1;
        hold_until_accepted();
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            stim_state = lcg_next(stim_state);
            // Idle gap on about one sample in four
            if (stim_state[31:30] == 2'b00) begin
                next_cycle();
            end
            draw_sample();
            in_valid = 1'b1;
            hold_until_accepted();
        end
    endtask

    task automatic drain_and_check();
        int waited;
        waited = 0;
        while ((expected_q.size() != 0 || out_valid) && waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (expected_q.size() != 0 || out_valid) begin
            $display("Timeout in %s: the pipeline did not drain", test_name);
            error_count++;
        end
        check_value({test_name, " rate"}, FACTOR * in_count, out_count);
    endtask

    task automatic stall_test();
        int   waited;
        logic stalled;
        start_test("stall");
        set_ready_mode(2);
        waited  = 0;
        stalled = 1'b0;
        while (!stalled && waited < ACCEPT_TIMEOUT) begin
            draw_sample();
            in_valid = 1'b1;
            @(negedge clock);
            stalled = !in_ready;
            next_cycle();
            waited++;
        end
        if (!stalled) begin
            $display("Timeout in stall: o_in_ready never dropped with the output stalled");
            error_count++;
            in_valid = 1'b0;
        end
        repeat (5) next_cycle();
        set_ready_mode(0);
        if (stalled) begin
            hold_until_accepted();
        end
        send_random(20);
        drain_and_check();
    endtask

    task automatic reset_midstream();
        start_test("reset");
        set_ready_mode(1);
        send_random(12);
        // Samples still in flight when reset hits
        tb_reset = 1'b1;
        in_valid = 1'b0;
        model_reset();
        repeat (2) next_cycle();
        tb_reset = 1'b0;
        send_random(30);
        drain_and_check();
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (reset && waited < 20);
        if (reset) begin
            $display("Timeout: reset was never released");
            error_count++;
        end
        next_cycle();
    endtask

    initial begin
        in_valid    = 1'b0;
        in_inph     = '0;
        in_quad     = '0;
        tb_reset    = 1'b0;
        out_ready   = 1'b1;
        ready_mode  = 0;
        error_count = 0;
        stim_state  = 32'd57;
        ready_state = lcg_next(32'd57);
        model_reset();
        wait_reset_release();

        start_test("impulse");
        send_sample(1, 1);
        repeat (STAGES) send_sample(0, 0);
        drain_and_check();

        start_test("random");
        send_random(40);
        drain_and_check();

        start_test("backpressure");
        set_ready_mode(1);
        send_random(40);
        drain_and_check();
        set_ready_mode(0);

        stall_test();
        reset_midstream();

        $display("Summary: %0d check errors, %0d assertion failures",
                 error_count, i_dut.i_sva.fail_count);
        if (error_count == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : cic_interp_tb

`default_nettype wire

// ==== cic_interp_top.f ====
+incdir+.
cic_pkg.sv
iq_stream_if.sv
cic_comb_chain.sv
cic_sample_fifo.sv
cic_integrator_chain.sv
cic_interp_top.sv
tb_clock_gen.sv
cic_interp_sva.sv
cic_interp_tb.sv

// ==== Bender.yml ====
package:
  name: cic_interp

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cic_pkg.sv
      - iq_stream_if.sv
      - cic_comb_chain.sv
      - cic_sample_fifo.sv
      - cic_integrator_chain.sv
      - cic_interp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - cic_interp_sva.sv
      - cic_interp_tb.sv
